/* sources.f */
design/ucodePkg.sv
design/opcodeDecoder.sv
design/ucodeRom.sv
design/ucodeSequencer.sv
design/cpuRegisters.sv
design/aluFlags.sv
design/ucodeCpu.sv
sim/ucodeCpu_properties.sv
sim/ucodeCpuTb.sv

/* Bender.yml */
package:
  name: ucode_cpu

sources:
  # Package first, then the RTL blocks and the top level
  - design/ucodePkg.sv
  - design/opcodeDecoder.sv
  - design/ucodeRom.sv
  - design/ucodeSequencer.sv
  - design/cpuRegisters.sv
  - design/aluFlags.sv
  - design/ucodeCpu.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/ucodeCpu_properties.sv
      - sim/ucodeCpuTb.sv

/* sim/ucodeCpuTb.sv */
`timescale 1ns/1ps

module ucodeCpuTb;

	// Random program source
	localparam logic [31:0] seedInit  = 32'h8a6c;
	localparam int          progInstr = 200;
	// Opcodes outside the kept set, all single byte
	localparam logic [47:0] unknownOps = 48'h01_2F_76_AF_CB_D3;

	logic        clock;
	logic        rst;
	logic [7:0]  memReadData;
	logic [15:0] memAddr;
	logic        memWrite;
	logic [7:0]  memWriteData;
	logic        retire;

	logic [7:0]  mem [0:65535];
	logic [15:0] readAddr;
	logic [31:0] lcgState;
	logic [15:0] endAddr;
	int          wp;
	int          instCount;

	// Instruction-level model state and expected traffic
	logic [7:0]  regs [0:7];
	logic        zModel;
	logic        modelReady = 1'b0;
	int          modelCount = 0;
	logic [15:0] expPc[$];
	logic [15:0] expWrAddr[$];
	logic [7:0]  expWrData[$];

	logic [15:0] wantAddr;
	logic [7:0]  wantData;
	logic [15:0] wantPc;
	logic        finished = 1'b0;
	int          retired = 0;
	int          writeIdx = 0;
	int          errReset = 0;
	int          errStore = 0;
	int          errFetch = 0;
	int          errCount = 0;
	int          passCount = 0;
	int          failCount = 0;

	ucodeCpu ucodeCpu_i
	(
		.clock        (clock),
		.rst          (rst),
		.memReadData  (memReadData),
		.memAddr      (memAddr),
		.memWrite     (memWrite),
		.memWriteData (memWriteData),
		.retire       (retire)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	////////////////////
	// Random program
	////////////////////

	function automatic int randBelow(input int n);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return int'(lcgState[30:8]) % n;
	endfunction

	// Any 8-bit register, index 6 is (HL) and never picked
	function automatic logic [2:0] regPick();
		int r;
		r = randBelow(7);
		return (r == 6) ? 3'd7 : r[2:0];
	endfunction

	// INC r, DEC r, ADD A,r or SUB A,r
	function automatic logic [7:0] aluOpcode();
		logic [2:0] r;
		r = regPick();
		case (randBelow(4))
			0:       return {2'b00, r, 3'b100};
			1:       return {2'b00, r, 3'b101};
			2:       return {5'b10000, r};
			default: return {5'b10010, r};
		endcase
	endfunction

	task automatic putByte(input logic [7:0] b);
		mem[wp[15:0]] = b;
		wp++;
	endtask

	// HL always lands in the data region above the code
	task automatic putLdHl();
		logic [15:0] nn;
		nn = 16'h8000 + 16'(randBelow(4096));
		putByte(8'h21);
		putByte(nn[7:0]);
		putByte(nn[15:8]);
		instCount++;
	endtask

	task automatic putStores();
		repeat (1 + randBelow(3))
		begin
			putByte(randBelow(2) ? 8'h77 : 8'h22);
			instCount++;
		end
	endtask

	// Taken branch skips the LD (HL+),A so the next store address moves
	task automatic putBranchStores();
		putLdHl();
		putByte(randBelow(2) ? 8'h28 : 8'h20);
		putByte(8'h01);
		putByte(8'h22);
		putByte(8'h77);
		instCount += 3;
	endtask

	task automatic genProgram();
		logic [2:0]  r;
		logic [7:0]  n8;
		logic [15:0] target;
		int          k;
		wp = 0;
		instCount = 0;
		while (instCount < progInstr)
		begin
			case (randBelow(6))
				0:
				begin
					// Immediate loads then a store group
					repeat (1 + randBelow(2))
					begin
						r = regPick();
						putByte({2'b00, r, 3'b110});
						putByte(8'(randBelow(256)));
						instCount++;
					end
					putLdHl();
					putStores();
				end
				1:
				begin
					repeat (1 + randBelow(3))
					begin
						putByte(aluOpcode());
						instCount++;
					end
					putBranchStores();
				end
				2:
				begin
					// CP against A itself about half the time
					n8 = 8'(randBelow(256));
					putByte(8'h3E);
					putByte(n8);
					putByte(8'hFE);
					putByte(randBelow(2) ? n8 : 8'(randBelow(256)));
					instCount += 2;
					putBranchStores();
				end
				3:
				begin
					// Forward hop, store, backward JR and out again
					putLdHl();
					putByte(8'h18);
					putByte(8'h03);
					putByte(8'h77);
					putByte(8'h18);
					putByte(8'h02);
					putByte(8'h18);
					putByte(8'hFB);
					instCount += 4;
				end
				4:
				begin
					// JP over filler that never runs
					k = 1 + randBelow(3);
					target = 16'(wp + 3 + k);
					putByte(8'hC3);
					putByte(target[7:0]);
					putByte(target[15:8]);
					repeat (k) putByte(8'h76);
					instCount++;
				end
				default:
				begin
					putByte(unknownOps[8 * randBelow(6) +: 8]);
					putByte(8'h00);
					instCount += 2;
				end
			endcase
		end
		// Park on JR -2
		endAddr = wp[15:0];
		putByte(8'h18);
		putByte(8'hFE);
	endtask

	////////////////////
	// Reference model
	////////////////////

	task automatic runModel();
		logic [15:0] pc;
		logic [15:0] hl;
		logic [15:0] sext;
		logic [7:0]  op;
		logic [7:0]  arg;
		for (int i = 0; i < 8; i++)
			regs[i] = 8'h00;
		zModel = 1'b0;
		pc = 16'h0000;
		while (pc != endAddr && modelCount < 4 * progInstr)
		begin
			op = mem[pc];
			arg = mem[pc + 16'd1];
			hl = {regs[4], regs[5]};
			sext = {{8{arg[7]}}, arg};
			// LD r,n
			if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'd6)
			begin
				regs[op[5:3]] = arg;
				pc = pc + 16'd2;
			end
			// INC r and DEC r
			else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != 3'd6)
			begin
				regs[op[5:3]] = op[0] ? regs[op[5:3]] - 8'd1 : regs[op[5:3]] + 8'd1;
				zModel = regs[op[5:3]] == 8'h00;
				pc = pc + 16'd1;
			end
			// ADD A,r and SUB A,r
			else if (op[7:5] == 3'b100 && op[3] == 1'b0 && op[2:0] != 3'd6)
			begin
				regs[7] = op[4] ? regs[7] - regs[op[2:0]] : regs[7] + regs[op[2:0]];
				zModel = regs[7] == 8'h00;
				pc = pc + 16'd1;
			end
			else
			begin
				case (op)
					8'h21:
					begin
						regs[5] = arg;
						regs[4] = mem[pc + 16'd2];
						pc = pc + 16'd3;
					end
					8'h77, 8'h22:
					begin
						expWrAddr.push_back(hl);
						expWrData.push_back(regs[7]);
						if (op == 8'h22)
							{regs[4], regs[5]} = hl + 16'd1;
						pc = pc + 16'd1;
					end
					8'h18:   pc = pc + 16'd2 + sext;
					8'h28:   pc = zModel ? pc + 16'd2 + sext : pc + 16'd2;
					8'h20:   pc = !zModel ? pc + 16'd2 + sext : pc + 16'd2;
					8'hC3:   pc = {mem[pc + 16'd2], arg};
					8'hFE:
					begin
						zModel = regs[7] == arg;
						pc = pc + 16'd2;
					end
					// Unknown opcodes act as NOP
					default: pc = pc + 16'd1;
				endcase
			end
			modelCount++;
			expPc.push_back(pc);
		end
	endtask

	task automatic reportTest(input string name, input int errs);
		if (errs == 0)
		begin
			passCount++;
			$display("test %s passed", name);
		end
		else
		begin
			failCount++;
			$display("test %s failed with %0d errors", name, errs);
		end
	endtask

	////////////////////
	// Memory model
	////////////////////

	// Address and write strobe sampled mid-cycle
	always @(negedge clock)
	begin
		readAddr <= memAddr;
		if (memWrite && !rst)
		begin
			mem[memAddr] = memWriteData;
			if (expWrAddr.size() == 0)
			begin
				errStore++;
				$display("storeSequence: write of %h to %h that the model never makes",
					memWriteData, memAddr);
			end
			else
			begin
				wantAddr = expWrAddr.pop_front();
				wantData = expWrData.pop_front();
				if (memAddr !== wantAddr || memWriteData !== wantData)
				begin
					errStore++;
					$display("FAILED storeSequence write %0d: expected %h=%h actual %h=%h",
						writeIdx, wantAddr, wantData, memAddr, memWriteData);
				end
			end
			writeIdx++;
		end
	end

	// One cycle read latency
	always @(posedge clock)
	begin
		#1;
		memReadData = mem[readAddr];
	end

	////////////////////
	// Sequence
	////////////////////

	initial
	begin
		rst = 1'b1;
		memReadData = 8'h00;
		readAddr = 16'h0000;
		lcgState = seedInit;
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
		genProgram();
		runModel();
		modelReady = 1'b1;
		repeat (8) @(posedge clock);
		#1;
		rst = 1'b0;
		// First cycle out of reset is the fetch of address 0
		@(negedge clock);
		if (memAddr !== 16'h0000 || retire !== 1'b0)
		begin
			errReset++;
			$display("FAILED resetFetch: expected addr 0000 retire 0 actual addr %h retire %b",
				memAddr, retire);
		end
		reportTest("resetFetch", errReset);
		// Retire falls in the fetch cycle, memAddr is the next opcode
		while (!finished)
		begin
			@(negedge clock);
			if (retire)
			begin
				retired++;
				if (expPc.size() > 0)
				begin
					wantPc = expPc.pop_front();
					if (memAddr !== wantPc)
					begin
						errFetch++;
						$display("FAILED fetchSequence instruction %0d: expected %h actual %h",
							retired, wantPc, memAddr);
					end
				end
				finished = memAddr == endAddr;
			end
		end
		reportTest("fetchSequence", errFetch);
		if (retired != modelCount)
		begin
			errCount++;
			$display("FAILED retireCount: expected %0d actual %0d", modelCount, retired);
		end
		reportTest("retireCount", errCount);
		if (expWrAddr.size() != 0)
		begin
			errStore++;
			$display("storeSequence: %0d model writes never reached memory", expWrAddr.size());
		end
		reportTest("storeSequence", errStore);
		reportTest("properties", ucodeCpu_i.ucodeCpuProperties_i.assertFails);
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Ten cycles per instruction is above the longest flow
	initial
	begin
		wait (modelReady);
		#(modelCount * 10 * 20 + 2000);
		$display("watchdog: CPU stopped retiring after %0d of %0d instructions",
			retired, modelCount);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* sim/ucodeCpu_properties.sv */
`timescale 1ns/1ps

module ucodeCpuProperties
(
	input logic        clock,
	input logic        rst,
	input logic [15:0] memAddr,
	input logic        memWrite,
	input logic [7:0]  memWriteData,
	input logic        retire
);

	int assertFails = 0;

	// Quiet bus during reset and the cycle after
	resetQuiet: assert property (@(posedge clock) rst |=> !memWrite && !retire)
	else
	begin
		$error("memWrite or retire high during reset or right after it");
		assertFails++;
	end

	// Fetch step sits between two retires
	retireSingle: assert property (@(posedge clock) disable iff (rst) retire |=> !retire)
	else
	begin
		$error("retire high in two consecutive cycles");
		assertFails++;
	end

	writeKnown: assert property (@(posedge clock) disable iff (rst)
		memWrite |-> !$isunknown({memAddr, memWriteData}))
	else
	begin
		$error("memAddr or memWriteData unknown during a write");
		assertFails++;
	end

endmodule

bind ucodeCpu ucodeCpuProperties ucodeCpuProperties_i
(
	.clock        (clock),
	.rst          (rst),
	.memAddr      (memAddr),
	.memWrite     (memWrite),
	.memWriteData (memWriteData),
	.retire       (retire)
);

/* design/ucodeCpu.sv */
`timescale 1ns/1ps

module ucodeCpu import ucodePkg::*;
(
	input  logic        clock,
	input  logic        rst,
	input  logic [7:0]  memReadData,
	output logic [15:0] memAddr,
	output logic        memWrite,
	output logic [7:0]  memWriteData,
	output logic        retire
);

	////////////////////
	// Control path
	////////////////////

	logic [flowIdxWidth-1:0] startIdx;
	logic [flowIdxWidth-1:0] romAddr;
	logic [uopWidth-1:0]     uop;
	logic                    fetch;
	logic                    zeroFlag;

	// Datapath wires
	logic [15:0] aluIn;
	logic [15:0] scratch;
	logic [15:0] aluResult;
	logic [3:0]  flags;
	logic [3:0]  newFlags;

	// Opcode is decoded straight off the read bus
	opcodeDecoder opcodeDecoder_i
	(
		.opcode   (memReadData),
		.startIdx (startIdx)
	);

	ucodeSequencer ucodeSequencer_i
	(
		.clock    (clock),
		.rst      (rst),
		.startIdx (startIdx),
		.uop      (uop),
		.zeroFlag (zeroFlag),
		.romAddr  (romAddr),
		.fetch    (fetch),
		.retire   (retire)
	);

	ucodeRom ucodeRom_i
	(
		.romAddr (romAddr),
		.uop     (uop)
	);

	////////////////////
	// Datapath
	////////////////////

	cpuRegisters cpuRegisters_i
	(
		.clock        (clock),
		.rst          (rst),
		.uop          (uop),
		.fetch        (fetch),
		.memReadData  (memReadData),
		.aluResult    (aluResult),
		.newFlags     (newFlags),
		.aluIn        (aluIn),
		.scratch      (scratch),
		.flags        (flags),
		.zeroFlag     (zeroFlag),
		.memAddr      (memAddr),
		.memWrite     (memWrite),
		.memWriteData (memWriteData)
	);

	aluFlags aluFlags_i
	(
		.uop       (uop),
		.aluIn     (aluIn),
		.scratch   (scratch),
		.flagsIn   (flags),
		.aluResult (aluResult),
		.newFlags  (newFlags)
	);

endmodule

/* design/aluFlags.sv */
`timescale 1ns/1ps

module aluFlags import ucodePkg::*;
(
	input  logic [uopWidth-1:0] uop,
	input  logic [15:0]         aluIn,
	input  logic [15:0]         scratch,
	input  logic [3:0]          flagsIn,
	output logic [15:0]         aluResult,
	output logic [3:0]          newFlags
);

	logic [actWidth-1:0] act;
	logic [15:0]         signExt;
	logic [8:0]          addLow;
	logic [4:0]          addNib;

	assign act = uop[opnWidth +: actWidth];

	// Byte operands sign extended, relative jump offsets need it
	assign signExt = {{8{aluIn[7]}}, aluIn[7:0]};
	assign addLow  = {1'b0, scratch[7:0]} + {1'b0, aluIn[7:0]};
	assign addNib  = {1'b0, scratch[3:0]} + {1'b0, aluIn[3:0]};

	always_comb
	begin
		aluResult = aluIn;
		newFlags  = flagsIn;
		case (act)
			actInc16:
			begin
				aluResult       = aluIn + 16'd1;
				newFlags[flagN] = 1'b0;
				newFlags[flagH] = aluIn[3:0] == 4'hF;
			end
			actDec16:
			begin
				aluResult       = aluIn - 16'd1;
				newFlags[flagN] = 1'b1;
				newFlags[flagH] = aluIn[3:0] == 4'h0;
			end
			actAddx16:
			begin
				aluResult       = scratch + signExt;
				newFlags[flagN] = 1'b0;
				newFlags[flagH] = addNib[4];
				newFlags[flagC] = addLow[8];
			end
			actSubx16:
			begin
				aluResult       = scratch - aluIn;
				newFlags[flagN] = 1'b1;
				newFlags[flagH] = scratch[3:0] < aluIn[3:0];
				newFlags[flagC] = scratch[7:0] < aluIn[7:0];
			end
			default:
				aluResult = aluIn;
		endcase
		// Z on the byte result, INC and DEC keep C
		newFlags[flagZ] = aluResult[7:0] == 8'd0;
	end

endmodule

/* design/cpuRegisters.sv */
`timescale 1ns/1ps

module cpuRegisters import ucodePkg::*;
(
	input  logic                clock,
	input  logic                rst,
	input  logic [uopWidth-1:0] uop,
	input  logic                fetch,
	input  logic [7:0]          memReadData,
	input  logic [15:0]         aluResult,
	input  logic [3:0]          newFlags,
	output logic [15:0]         aluIn,
	output logic [15:0]         scratch,
	output logic [3:0]          flags,
	output logic                zeroFlag,
	output logic [15:0]         memAddr,
	output logic                memWrite,
	output logic [7:0]          memWriteData
);

	logic [flowWidth-1:0] flow;
	logic [actWidth-1:0]  act;
	logic [opnWidth-1:0]  opn;
	logic [7:0]           regA, regB, regC, regD, regE, regH, regL, regX8;
	logic [15:0]          pc;
	logic [15:0]          pcNext;
	logic                 wrEn;
	logic [15:0]          wrData;

	assign flow = uop[uopWidth-1 -: flowWidth];
	assign act  = uop[opnWidth +: actWidth];
	assign opn  = uop[opnWidth-1:0];

	// Fetch steps PC past the opcode
	assign pcNext = (fetch || flow == flowInc) ? pc + 16'd1 : pc;

	// Operand select
	always_comb
	begin
		case (opn)
			opnB:    aluIn = {8'd0, regB};
			opnC:    aluIn = {8'd0, regC};
			opnD:    aluIn = {8'd0, regD};
			opnE:    aluIn = {8'd0, regE};
			opnH:    aluIn = {8'd0, regH};
			opnL:    aluIn = {8'd0, regL};
			opnHl:   aluIn = {regH, regL};
			opnA:    aluIn = {8'd0, regA};
			opnPc:   aluIn = pc;
			opnX8:   aluIn = {8'd0, regX8};
			opnX16:  aluIn = scratch;
			default: aluIn = 16'd0;
		endcase
	end

	assign memWriteData = aluIn[7:0];
	assign memWrite     = !fetch && act == actSmw;
	assign zeroFlag     = flags[flagZ];

	// Writeback source for the operand
	always_comb
	begin
		wrEn   = 1'b0;
		wrData = aluResult;
		case (act)
			actSrm:
			begin
				wrEn   = 1'b1;
				wrData = {memReadData, memReadData};
			end
			actSrx16:
			begin
				wrEn   = 1'b1;
				wrData = scratch;
			end
			actInc16, actDec16:
				wrEn = 1'b1;
			default:
				wrEn = 1'b0;
		endcase
	end

	////////////////////
	// Register update
	////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			{regA, regB, regC, regD} <= 32'd0;
			{regE, regH, regL, regX8} <= 32'd0;
			pc      <= 16'd0;
			memAddr <= 16'd0;
			scratch <= 16'd0;
			flags   <= 4'd0;
		end
		else
		begin
			pc <= pcNext;
			if (fetch)
				memAddr <= pcNext;
			else
			begin
				case (act)
					// Address of PC follows a same-step increment
					actSma:
						memAddr <= (opn == opnPc) ? pcNext : aluIn;
					actSx16r:
						scratch <= aluIn;
					actAddx16, actSubx16:
						scratch <= aluResult;
					actSpc:
						pc <= aluIn;
					default:
						;
				endcase
				if (flow == flowEofFu || flow == flowUpdateFlags)
					flags <= newFlags;
				if (wrEn)
				begin
					case (opn)
						opnB:  regB <= wrData[7:0];
						opnC:  regC <= wrData[7:0];
						opnD:  regD <= wrData[7:0];
						opnE:  regE <= wrData[7:0];
						opnH:  regH <= wrData[7:0];
						opnL:  regL <= wrData[7:0];
						opnHl: {regH, regL} <= wrData;
						opnA:  regA <= wrData[7:0];
						opnPc: pc <= wrData;
						opnX8: regX8 <= wrData[7:0];
						// Byte reads shift in from the top, low byte first
						opnX16:
							scratch <= (act == actSrm) ? {memReadData, scratch[15:8]} : wrData;
						default:
							;
					endcase
				end
			end
		end
	end

endmodule

/* design/ucodeSequencer.sv */
`timescale 1ns/1ps

module ucodeSequencer import ucodePkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic [flowIdxWidth-1:0] startIdx,
	input  logic [uopWidth-1:0]     uop,
	input  logic                    zeroFlag,
	output logic [flowIdxWidth-1:0] romAddr,
	output logic                    fetch,
	output logic                    retire
);

	logic [flowWidth-1:0] flow;
	logic                 endStep;

	assign flow = uop[uopWidth-1 -: flowWidth];

	// End of flow, conditional ends look at the latched Z
	always_comb
	begin
		case (flow)
			flowEof, flowEofFu:
				endStep = 1'b1;
			flowEofZ:
				endStep = zeroFlag;
			flowEofNz:
				endStep = !zeroFlag;
			default:
				endStep = 1'b0;
		endcase
	end

	////////////////////
	// Flow index and fetch state
	////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			romAddr <= flowDefault;
			fetch   <= 1'b1;
			retire  <= 1'b0;
		end
		else
		begin
			retire <= 1'b0;
			if (fetch)
			begin
				// Opcode is on the read bus now
				romAddr <= startIdx;
				fetch   <= 1'b0;
			end
			else if (endStep)
			begin
				fetch  <= 1'b1;
				retire <= 1'b1;
			end
			else
				romAddr <= romAddr + 8'd1;
		end
	end

endmodule

/* design/ucodeRom.sv */
`timescale 1ns/1ps

module ucodeRom import ucodePkg::*;
(
	input  logic [flowIdxWidth-1:0] romAddr,
	output logic [uopWidth-1:0]     uop
);

	// Register selector taken from the strided index
	logic [opnWidth-1:0] regLdrn;
	logic [opnWidth-1:0] regUnary;
	logic [opnWidth-1:0] regBinary;

	assign regLdrn   = {2'b00, romAddr[3:1]};
	assign regUnary  = {2'b00, romAddr[2:0]};
	assign regBinary = {2'b00, romAddr[4:2]};

	// Fetch already points memAddr at PC+1 when step 0 starts
	always_comb
	begin
		casez (romAddr)
			////////////////////
			// Register families
			////////////////////
			// LD r,n : next byte arrives one step later
			8'b0001_???0: uop = {flowInc, actSma, opnPc};
			8'b0001_???1: uop = {flowEof, actSrm, regLdrn};
			// INC r / DEC r
			8'b0010_0???: uop = {flowEofFu, actInc16, regUnary};
			8'b0010_1???: uop = {flowEofFu, actDec16, regUnary};
			// ADD A,r
			8'b010?_??00: uop = {flowOp, actSx16r, opnA};
			8'b010?_??01: uop = {flowUpdateFlags, actAddx16, regBinary};
			8'b010?_??10: uop = {flowEof, actSrx16, opnA};
			// SUB A,r
			8'b011?_??00: uop = {flowOp, actSx16r, opnA};
			8'b011?_??01: uop = {flowUpdateFlags, actSubx16, regBinary};
			8'b011?_??10: uop = {flowEof, actSrx16, opnA};

			////////////////////
			// Single flows
			////////////////////
			flowNop:            uop = {flowEof, actNop, opnNull};
			// LD HL,nn
			flowLdHlnn:         uop = {flowInc, actSma, opnPc};
			flowLdHlnn + 8'd1:  uop = {flowInc, actSrm, opnL};
			flowLdHlnn + 8'd2:  uop = {flowOp, actSma, opnPc};
			flowLdHlnn + 8'd3:  uop = {flowEof, actSrm, opnH};
			// LD (HL),A
			flowLdHlmA:         uop = {flowOp, actSma, opnHl};
			flowLdHlmA + 8'd1:  uop = {flowOp, actSmw, opnA};
			flowLdHlmA + 8'd2:  uop = {flowOp, actSma, opnPc};
			flowLdHlmA + 8'd3:  uop = {flowEof, actNop, opnNull};
			// LD (HL+),A, HL bumped on the last step
			flowLdHliA:         uop = {flowOp, actSma, opnHl};
			flowLdHliA + 8'd1:  uop = {flowOp, actSmw, opnA};
			flowLdHliA + 8'd2:  uop = {flowOp, actSma, opnPc};
			flowLdHliA + 8'd3:  uop = {flowEof, actInc16, opnHl};
			// JR n, offset relative to the next opcode
			flowJrn:            uop = {flowInc, actSma, opnPc};
			flowJrn + 8'd1:     uop = {flowOp, actSrm, opnX8};
			flowJrn + 8'd2:     uop = {flowOp, actSx16r, opnPc};
			flowJrn + 8'd3:     uop = {flowOp, actAddx16, opnX8};
			flowJrn + 8'd4:     uop = {flowOp, actSma, opnX16};
			flowJrn + 8'd5:     uop = {flowEof, actSpc, opnX16};
			// JR Z,n  ends early when Z is clear
			flowJrzn:           uop = {flowInc, actSma, opnPc};
			flowJrzn + 8'd1:    uop = {flowEofNz, actSrm, opnX8};
			flowJrzn + 8'd2:    uop = {flowOp, actSx16r, opnPc};
			flowJrzn + 8'd3:    uop = {flowOp, actAddx16, opnX8};
			flowJrzn + 8'd4:    uop = {flowOp, actSma, opnX16};
			flowJrzn + 8'd5:    uop = {flowEof, actSpc, opnX16};
			// JR NZ,n  ends early when Z is set
			flowJrnzn:          uop = {flowInc, actSma, opnPc};
			flowJrnzn + 8'd1:   uop = {flowEofZ, actSrm, opnX8};
			flowJrnzn + 8'd2:   uop = {flowOp, actSx16r, opnPc};
			flowJrnzn + 8'd3:   uop = {flowOp, actAddx16, opnX8};
			flowJrnzn + 8'd4:   uop = {flowOp, actSma, opnX16};
			flowJrnzn + 8'd5:   uop = {flowEof, actSpc, opnX16};
			// JP nn, both bytes shifted into scratch low first
			flowJpnn:           uop = {flowInc, actSma, opnPc};
			flowJpnn + 8'd1:    uop = {flowOp, actSrm, opnX16};
			flowJpnn + 8'd2:    uop = {flowOp, actSrm, opnX16};
			flowJpnn + 8'd3:    uop = {flowOp, actSma, opnX16};
			flowJpnn + 8'd4:    uop = {flowEof, actSpc, opnX16};
			// CP n, flags only
			flowCpn:            uop = {flowInc, actSma, opnPc};
			flowCpn + 8'd1:     uop = {flowOp, actSrm, opnX8};
			flowCpn + 8'd2:     uop = {flowOp, actSx16r, opnA};
			flowCpn + 8'd3:     uop = {flowEofFu, actSubx16, opnX8};
			// Flow 0 and unused slots
			default:            uop = {flowEof, actNop, opnNull};
		endcase
	end

endmodule

/* design/opcodeDecoder.sv */
`timescale 1ns/1ps

module opcodeDecoder import ucodePkg::*;
(
	input  logic [7:0]              opcode,
	output logic [flowIdxWidth-1:0] startIdx
);

	// Register families add the rrr field to their base
	always_comb
	begin
		case (opcode)
			opNop:
				startIdx = flowNop;
			opLdrnB, opLdrnC, opLdrnD, opLdrnE, opLdrnH, opLdrnL, opLdrnA:
				startIdx = flowLdrn | {4'd0, opcode[5:3], 1'b0};
			opIncrB, opIncrC, opIncrD, opIncrE, opIncrH, opIncrL, opIncrA:
				startIdx = flowIncr | {5'd0, opcode[5:3]};
			opDecrB, opDecrC, opDecrD, opDecrE, opDecrH, opDecrL, opDecrA:
				startIdx = flowDecr | {5'd0, opcode[5:3]};
			// Three steps per flow in four slots per register
			opAddrB, opAddrC, opAddrD, opAddrE, opAddrH, opAddrL, opAddrA:
				startIdx = flowAddr | {3'd0, opcode[2:0], 2'b00};
			opSubrB, opSubrC, opSubrD, opSubrE, opSubrH, opSubrL, opSubrA:
				startIdx = flowSubr | {3'd0, opcode[2:0], 2'b00};
			opLdHlnn:
				startIdx = flowLdHlnn;
			opLdHlmA:
				startIdx = flowLdHlmA;
			opLdHliA:
				startIdx = flowLdHliA;
			opJrn:
				startIdx = flowJrn;
			opJrzn:
				startIdx = flowJrzn;
			opJrnzn:
				startIdx = flowJrnzn;
			opJpnn:
				startIdx = flowJpnn;
			opCpn:
				startIdx = flowCpn;
			// Anything else retires like a NOP
			default:
				startIdx = flowDefault;
		endcase
	end

endmodule

/* design/ucodePkg.sv */
package ucodePkg;

	////////////////////
	// Micro-op word layout
	////////////////////

	// Word is {flow, action, operand}
	localparam int uopWidth     = 13;
	localparam int flowWidth    = 3;
	localparam int actWidth     = 5;
	localparam int opnWidth     = 5;
	localparam int flowIdxWidth = 8;

	// Flow field
	localparam logic [2:0] flowOp          = 3'd0;
	localparam logic [2:0] flowInc         = 3'd1;
	localparam logic [2:0] flowEof         = 3'd2;
	localparam logic [2:0] flowEofZ        = 3'd3;
	localparam logic [2:0] flowEofNz       = 3'd4;
	localparam logic [2:0] flowEofFu       = 3'd5;
	localparam logic [2:0] flowUpdateFlags = 3'd6;

	// Action field
	localparam logic [4:0] actNop    = 5'd0;
	localparam logic [4:0] actSma    = 5'd1;
	localparam logic [4:0] actSmw    = 5'd2;
	localparam logic [4:0] actSrm    = 5'd3;
	localparam logic [4:0] actSx16r  = 5'd4;
	localparam logic [4:0] actSrx16  = 5'd5;
	localparam logic [4:0] actInc16  = 5'd6;
	localparam logic [4:0] actDec16  = 5'd7;
	localparam logic [4:0] actAddx16 = 5'd8;
	localparam logic [4:0] actSubx16 = 5'd9;
	localparam logic [4:0] actSpc    = 5'd10;

	// Operand field, 8-bit registers follow the opcode rrr encoding
	localparam logic [4:0] opnB    = 5'd0;
	localparam logic [4:0] opnC    = 5'd1;
	localparam logic [4:0] opnD    = 5'd2;
	localparam logic [4:0] opnE    = 5'd3;
	localparam logic [4:0] opnH    = 5'd4;
	localparam logic [4:0] opnL    = 5'd5;
	localparam logic [4:0] opnHl   = 5'd6;
	localparam logic [4:0] opnA    = 5'd7;
	localparam logic [4:0] opnPc   = 5'd8;
	localparam logic [4:0] opnX8   = 5'd9;
	localparam logic [4:0] opnX16  = 5'd10;
	localparam logic [4:0] opnNull = 5'd11;

	// Flag bit positions in {Z, N, H, C}
	localparam int flagZ = 3;
	localparam int flagN = 2;
	localparam int flagH = 1;
	localparam int flagC = 0;

	////////////////////
	// Opcodes
	////////////////////

	localparam logic [7:0] opNop    = 8'h00;
	localparam logic [7:0] opLdrnB  = 8'h06;
	localparam logic [7:0] opLdrnC  = 8'h0E;
	localparam logic [7:0] opLdrnD  = 8'h16;
	localparam logic [7:0] opLdrnE  = 8'h1E;
	localparam logic [7:0] opLdrnH  = 8'h26;
	localparam logic [7:0] opLdrnL  = 8'h2E;
	localparam logic [7:0] opLdrnA  = 8'h3E;
	localparam logic [7:0] opIncrB  = 8'h04;
	localparam logic [7:0] opIncrC  = 8'h0C;
	localparam logic [7:0] opIncrD  = 8'h14;
	localparam logic [7:0] opIncrE  = 8'h1C;
	localparam logic [7:0] opIncrH  = 8'h24;
	localparam logic [7:0] opIncrL  = 8'h2C;
	localparam logic [7:0] opIncrA  = 8'h3C;
	localparam logic [7:0] opDecrB  = 8'h05;
	localparam logic [7:0] opDecrC  = 8'h0D;
	localparam logic [7:0] opDecrD  = 8'h15;
	localparam logic [7:0] opDecrE  = 8'h1D;
	localparam logic [7:0] opDecrH  = 8'h25;
	localparam logic [7:0] opDecrL  = 8'h2D;
	localparam logic [7:0] opDecrA  = 8'h3D;
	localparam logic [7:0] opAddrB  = 8'h80;
	localparam logic [7:0] opAddrC  = 8'h81;
	localparam logic [7:0] opAddrD  = 8'h82;
	localparam logic [7:0] opAddrE  = 8'h83;
	localparam logic [7:0] opAddrH  = 8'h84;
	localparam logic [7:0] opAddrL  = 8'h85;
	localparam logic [7:0] opAddrA  = 8'h87;
	localparam logic [7:0] opSubrB  = 8'h90;
	localparam logic [7:0] opSubrC  = 8'h91;
	localparam logic [7:0] opSubrD  = 8'h92;
	localparam logic [7:0] opSubrE  = 8'h93;
	localparam logic [7:0] opSubrH  = 8'h94;
	localparam logic [7:0] opSubrL  = 8'h95;
	localparam logic [7:0] opSubrA  = 8'h97;
	localparam logic [7:0] opLdHlnn = 8'h21;
	localparam logic [7:0] opLdHlmA = 8'h77;
	localparam logic [7:0] opLdHliA = 8'h22;
	localparam logic [7:0] opJrn    = 8'h18;
	localparam logic [7:0] opJrzn   = 8'h28;
	localparam logic [7:0] opJrnzn  = 8'h20;
	localparam logic [7:0] opJpnn   = 8'hC3;
	localparam logic [7:0] opCpn    = 8'hFE;

	////////////////////
	// Flow start indices
	////////////////////

	// Register families are strided so the ROM reads rrr from index bits
	localparam logic [7:0] flowDefault = 8'h00;
	localparam logic [7:0] flowLdrn    = 8'h10;
	localparam logic [7:0] flowIncr    = 8'h20;
	localparam logic [7:0] flowDecr    = 8'h28;
	localparam logic [7:0] flowAddr    = 8'h40;
	localparam logic [7:0] flowSubr    = 8'h60;
	localparam logic [7:0] flowNop     = 8'h80;
	localparam logic [7:0] flowLdHlnn  = 8'h81;
	localparam logic [7:0] flowLdHlmA  = 8'h85;
	localparam logic [7:0] flowLdHliA  = 8'h89;
	localparam logic [7:0] flowJrn     = 8'h90;
	localparam logic [7:0] flowJrzn    = 8'h98;
	localparam logic [7:0] flowJrnzn   = 8'hA0;
	localparam logic [7:0] flowJpnn    = 8'hA8;
	localparam logic [7:0] flowCpn     = 8'hB0;

endpackage
